// ==== Makefile ====
TOP := tb_cpu_debug_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== bench/tb_cpu_debug_top.sv ====
`timescale 1ns/1ps

module tb_cpu_debug_top;
	import isa_pkg::*;
	import debug_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int WAIT_LIMIT  = 100;

	logic        clk;
	logic        reset;
	logic        inst_valid;
	inst_word_u  inst_word;
	logic        credit_return;
	logic [15:0] sw;
	logic [15:0] led_data;

	// Model of the architectural state
	reg_value_t  model_regs [REG_COUNT];
	logic        model_zero;
	logic        model_derr;
	reg_value_t  model_last_res;
	int          sent = 0;
	int          returned = 0;

	cpu_debug_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_cpu_debug_top (
		.clk           (clk),
		.reset         (reset),
		.inst_valid    (inst_valid),
		.inst_word     (inst_word),
		.credit_return (credit_return),
		.sw            (sw),
		.led_data      (led_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// One credit back per pop
	always @(negedge clk) begin
		if (!reset && credit_return === 1'b1) begin
			returned = returned + 1;
			if (returned > sent) begin
				$display("A credit came back at %0t with no instruction outstanding", $time);
				$display(">>> FAIL");
				$fatal(1, "extra credit returned");
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic reg_value_t ref_execute(input inst_word_u w, output logic defined);
		reg_value_t res;
		defined = 1'b1;
		res     = '0;
		case (w.r.opcode)
			ADD:     res = model_regs[w.r.rs] + model_regs[w.r.rt];
			SUB:     res = model_regs[w.r.rs] - model_regs[w.r.rt];
			AND:     res = model_regs[w.r.rs] & model_regs[w.r.rt];
			OR:      res = model_regs[w.r.rs] | model_regs[w.r.rt];
			LI:      res = 16'(w.i.imm8);
			ADDI:    res = model_regs[w.i.rd] + 16'($signed(w.i.imm8));
			default: defined = 1'b0;
		endcase
		return res;
	endfunction

	task automatic apply_model(input inst_word_u w);
		reg_value_t res;
		logic       defined;
		res = ref_execute(w, defined);
		if (defined) begin
			model_regs[w.r.rd] = res;
			model_last_res     = res;
			model_zero         = (res == 16'h0000);
		end else begin
			model_derr = 1'b1;
		end
	endtask

	// Low byte is {rs, rt} or imm8, depending on the opcode
	function automatic inst_word_u make_inst(input opcode_t op, input reg_addr_t rd,
			input logic [7:0] low);
		inst_word_u w;
		w.i.opcode = op;
		w.i.rd     = rd;
		w.i.imm8   = low;
		return w;
	endfunction

	function automatic inst_word_u random_alu_word();
		inst_word_u w;
		w.r.rd = 4'($urandom_range(0, 15));
		w.r.rs = 4'($urandom_range(0, 15));
		w.r.rt = 4'($urandom_range(0, 15));
		case ($urandom_range(0, 4))
			0:       w.r.opcode = ADD;
			1:       w.r.opcode = SUB;
			2:       w.r.opcode = AND;
			3:       w.r.opcode = OR;
			default: w.r.opcode = ADDI;
		endcase
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Sender and waits
	////////////////////////////////////////////////////////////////////////////

	task automatic send_inst(input inst_word_u w);
		int cycles;
		cycles = 0;
		while (QUEUE_DEPTH + returned - sent <= 0) begin
			inst_valid = 1'b0;
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("No credit came back after %0d cycles", WAIT_LIMIT);
				$display(">>> FAIL");
				$fatal(1, "credit wait timed out");
			end
		end
		inst_valid = 1'b1;
		inst_word  = w;
		sent++;
		apply_model(w);
		@(posedge clk);
		#1;
		inst_valid = 1'b0;
	endtask

	// Poll the status view until the queue reads empty
	task automatic wait_drain();
		logic [15:0] value;
		int          polls;
		polls = 0;
		read_view(VIEW_STATUS, 8'h00, value);
		while (value[STATUS_EMPTY_BIT] !== 1'b1) begin
			polls++;
			if (polls > WAIT_LIMIT) begin
				$display("Queue did not drain, %0d sent and %0d credits back", sent, returned);
				$display(">>> FAIL");
				$fatal(1, "drain wait timed out");
			end
			read_view(VIEW_STATUS, 8'h00, value);
		end
	endtask

	// LED output lags the switches by one edge
	task automatic read_view(input view_sel_t sel, input logic [7:0] low,
			output logic [15:0] value);
		sw = {sel, low};
		@(posedge clk);
		@(negedge clk);
		value = led_data;
		@(posedge clk);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string view, input reg_value_t got, input reg_value_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, view, got, exp);
			$display(">>> FAIL");
			$fatal(1, "view mismatch");
		end
	endtask

	task automatic check_status(input logic [15:0] got, input logic exp_empty,
			input logic exp_full, input logic exp_zero, input logic exp_derr,
			input logic [3:0] exp_count);
		logic [15:0] exp;
		exp = '0;
		exp[STATUS_EMPTY_BIT] = exp_empty;
		exp[STATUS_FULL_BIT]  = exp_full;
		exp[STATUS_ZERO_BIT]  = exp_zero;
		exp[STATUS_DERR_BIT]  = exp_derr;
		exp[STATUS_COUNT_MSB:STATUS_COUNT_LSB] = exp_count;
		if (got !== exp) begin
			$display("[FAIL] %0t status: got empty=%b full=%b zero=%b derr=%b count=%0d, expected %h",
				$time, got[15], got[14], got[13], got[12], got[11:8], exp);
			$display(">>> FAIL");
			$fatal(1, "status mismatch");
		end
	endtask

	// Drained queue, flags, last result and every register
	task automatic check_idle();
		logic [15:0] value;
		read_view(VIEW_STATUS, 8'h00, value);
		check_status(value, 1'b1, 1'b0, model_zero, model_derr, 4'd0);
		read_view(VIEW_QHEAD, 8'h00, value);
		check_word("queue head", value, 16'h0000);
		read_view(VIEW_LAST_RES, 8'h00, value);
		check_word("last result", value, model_last_res);
		for (int k = 0; k < REG_COUNT; k++) begin
			read_view(VIEW_REG_BASE | 8'(k), 8'h00, value);
			check_word($sformatf("register %0d", k), value, model_regs[k]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] value;
		logic [15:0] sw_probe;
		logic [3:0]  ptr;
		inst_word_u  w;
		int          burst_start;

		void'($urandom(54215));
		reset          = 1'b1;
		inst_valid     = 1'b0;
		inst_word      = '0;
		sw             = '0;
		model_zero     = 1'b0;
		model_derr     = 1'b0;
		model_last_res = '0;
		for (int k = 0; k < REG_COUNT; k++)
			model_regs[k] = '0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_word("led_data in reset", led_data, 16'h0000);
		@(posedge clk);
		#1;
		reset = 1'b0;
		check_idle();

		for (int k = 0; k < REG_COUNT; k++)
			send_inst(make_inst(LI, 4'(k), 8'($urandom)));
		wait_drain();
		check_idle();

		// Wrap below zero, FFFF + FFFF, then back up to zero
		send_inst(make_inst(LI, 4'd1, 8'h01));
		send_inst(make_inst(ADDI, 4'd1, 8'hFE));
		send_inst(make_inst(ADD, 4'd2, {4'd1, 4'd1}));
		send_inst(make_inst(ADDI, 4'd1, 8'h01));
		wait_drain();
		check_idle();

		for (int round = 0; round < 3; round++) begin
			for (int n = 0; n < 16; n++)
				send_inst(random_alu_word());
			wait_drain();
			check_idle();
		end

		burst_start = returned;
		for (int n = 0; n < 3 * QUEUE_DEPTH; n++)
			send_inst(make_inst(OR, 4'(n), {4'(n + 1), 4'(n + 2)}));
		wait_drain();
		check_word("credits returned", 16'(returned - burst_start), 16'(3 * QUEUE_DEPTH));
		check_idle();

		send_inst(make_inst(LI, 4'd5, 8'h3C));
		send_inst(make_inst(SUB, 4'd3, {4'd5, 4'd5}));
		wait_drain();
		read_view(VIEW_STATUS, 8'h00, value);
		check_status(value, 1'b1, 1'b0, 1'b1, 1'b0, 4'd0);
		check_idle();

		// Opcode 11 is undefined
		w = 16'hB7A5;
		send_inst(w);
		wait_drain();
		read_view(VIEW_STATUS, 8'h00, value);
		check_status(value, 1'b1, 1'b0, 1'b1, 1'b1, 4'd0);
		check_idle();

		// Head view catches the word in its only queued cycle
		sw = {VIEW_QHEAD, 8'h00};
		w  = make_inst(LI, 4'd1, 8'h42);
		send_inst(w);
		@(posedge clk);
		@(negedge clk);
		check_word("queue head", led_data, w);
		@(posedge clk);
		#1;
		w = make_inst(ADD, 4'd4, {4'd1, 4'd5});
		send_inst(w);
		wait_drain();
		read_view(VIEW_STATUS, 8'h00, value);
		check_status(value, 1'b1, 1'b0, 1'b0, 1'b1, 4'd0);
		check_idle();

		read_view(VIEW_LAST_INST, 8'h00, value);
		check_word("last instruction", value, w);
		ptr = 4'(sent % QUEUE_DEPTH);
		read_view(VIEW_QPTR, 8'h00, value);
		check_word("queue pointers", value, {4'h0, ptr, 4'h0, ptr});
		sw_probe = {8'h7A, 8'($urandom)};
		read_view(sw_probe[15:8], sw_probe[7:0], value);
		check_word("unused selector", value, sw_probe);

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== design/alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec (
	input  logic                clk,
	input  logic                reset,
	input  logic                head_valid,
	input  isa_pkg::inst_word_u head_word,
	input  isa_pkg::reg_value_t rd_data1,
	input  isa_pkg::reg_value_t rd_data2,
	output logic                pop,
	output isa_pkg::reg_addr_t  rd_addr1,
	output isa_pkg::reg_addr_t  rd_addr2,
	output logic                wr_en,
	output isa_pkg::reg_addr_t  wr_addr,
	output isa_pkg::reg_value_t wr_data,
	output isa_pkg::inst_word_u last_inst,
	output isa_pkg::reg_value_t last_res,
	output logic                zero_flag,
	output logic                decode_error
);
	import isa_pkg::*;

	reg_value_t result;
	reg_value_t imm_sext;
	logic       op_defined;

	// Single stage, so the head is always consumed
	assign pop = head_valid;

	// ADDI reads its own destination on port 1
	assign rd_addr1 = (head_word.r.opcode == ADDI) ? head_word.i.rd : head_word.r.rs;
	assign rd_addr2 = head_word.r.rt;
	assign imm_sext = {{8{head_word.i.imm8[7]}}, head_word.i.imm8};

	always_comb begin
		op_defined = 1'b1;
		result     = '0;
		case (head_word.r.opcode)
			ADD:     result = rd_data1 + rd_data2;
			SUB:     result = rd_data1 - rd_data2;
			AND:     result = rd_data1 & rd_data2;
			OR:      result = rd_data1 | rd_data2;
			LI:      result = {8'h00, head_word.i.imm8};
			ADDI:    result = rd_data1 + imm_sext;
			default: op_defined = 1'b0;
		endcase
	end

	assign wr_en   = head_valid && op_defined;
	assign wr_addr = head_word.r.rd;
	assign wr_data = result;

	////////////////////////////////////////////////////////////////////////////
	// Flags and debug state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			last_inst    <= '0;
			last_res     <= '0;
			zero_flag    <= 1'b0;
			decode_error <= 1'b0;
		end else if (head_valid) begin
			last_inst <= head_word;
			if (op_defined) begin
				last_res  <= result;
				zero_flag <= (result == '0);
			end else begin
				decode_error <= 1'b1;
			end
		end
	end

	// Writes only come from a queued head
	a_wr_from_head: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> head_valid)
		else $error("alu_exec: write without a queued head");

endmodule

// ==== design/cpu_debug_top.sv ====
`timescale 1ns/1ps

module cpu_debug_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                inst_valid,
	input  isa_pkg::inst_word_u inst_word,
	output logic                credit_return,
	input  logic [15:0]         sw,
	output logic [15:0]         led_data
);
	import isa_pkg::*;

	logic         head_valid;
	inst_word_u   head_word;
	logic         pop;
	logic [3:0]   qfront;
	logic [3:0]   qtail;
	logic [3:0]   count;
	logic         empty;
	logic         full;

	reg_addr_t    rd_addr1;
	reg_addr_t    rd_addr2;
	reg_value_t   rd_data1;
	reg_value_t   rd_data2;
	logic         wr_en;
	reg_addr_t    wr_addr;
	reg_value_t   wr_data;
	logic [255:0] reg_debug;

	inst_word_u   last_inst;
	reg_value_t   last_res;
	logic         zero_flag;
	logic         decode_error;

	inst_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_inst_queue (
		.clk           (clk),
		.reset         (reset),
		.push          (inst_valid),
		.push_word     (inst_word),
		.pop           (pop),
		.head_valid    (head_valid),
		.head_word     (head_word),
		.credit_return (credit_return),
		.qfront        (qfront),
		.qtail         (qtail),
		.count         (count),
		.empty         (empty),
		.full          (full)
	);

	reg_file i_reg_file (
		.clk       (clk),
		.reset     (reset),
		.rd_addr1  (rd_addr1),
		.rd_addr2  (rd_addr2),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_data1  (rd_data1),
		.rd_data2  (rd_data2),
		.reg_debug (reg_debug)
	);

	alu_exec i_alu_exec (
		.clk          (clk),
		.reset        (reset),
		.head_valid   (head_valid),
		.head_word    (head_word),
		.rd_data1     (rd_data1),
		.rd_data2     (rd_data2),
		.pop          (pop),
		.rd_addr1     (rd_addr1),
		.rd_addr2     (rd_addr2),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.last_inst    (last_inst),
		.last_res     (last_res),
		.zero_flag    (zero_flag),
		.decode_error (decode_error)
	);

	led_ctrl i_led_ctrl (
		.clk          (clk),
		.reset        (reset),
		.sw           (sw),
		.qfront       (qfront),
		.qtail        (qtail),
		.count        (count),
		.empty        (empty),
		.full         (full),
		.head_word    (head_word),
		.last_inst    (last_inst),
		.last_res     (last_res),
		.zero_flag    (zero_flag),
		.decode_error (decode_error),
		.reg_debug    (reg_debug),
		.led_data     (led_data)
	);

endmodule

// ==== design/debug_pkg.sv ====
package debug_pkg;

	////////////////////////////////////////////////////////////////////////////
	// LED view selectors, taken from the switch upper byte
	////////////////////////////////////////////////////////////////////////////

	typedef logic [7:0] view_sel_t;

	localparam view_sel_t VIEW_STATUS    = 8'h00;
	localparam view_sel_t VIEW_LAST_INST = 8'h01;
	localparam view_sel_t VIEW_LAST_RES  = 8'h02;
	localparam view_sel_t VIEW_QPTR      = 8'h03;
	localparam view_sel_t VIEW_QHEAD     = 8'h04;

	// 8'h10 to 8'h1F pick register 0 to 15
	localparam view_sel_t VIEW_REG_BASE  = 8'h10;

	////////////////////////////////////////////////////////////////////////////
	// Status word layout
	////////////////////////////////////////////////////////////////////////////

	localparam int STATUS_EMPTY_BIT = 15;
	localparam int STATUS_FULL_BIT  = 14;
	localparam int STATUS_ZERO_BIT  = 13;
	localparam int STATUS_DERR_BIT  = 12;
	localparam int STATUS_COUNT_MSB = 11;
	localparam int STATUS_COUNT_LSB = 8;
	// Bits 7..0 read as zero

endpackage

// ==== design/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                push,
	input  isa_pkg::inst_word_u push_word,
	input  logic                pop,
	output logic                head_valid,
	output isa_pkg::inst_word_u head_word,
	output logic                credit_return,
	output logic [3:0]          qfront,
	output logic [3:0]          qtail,
	output logic [3:0]          count,
	output logic                empty,
	output logic                full
);
	import isa_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	inst_word_u       entries [QUEUE_DEPTH];
	logic [PTR_W-1:0] front;
	logic [PTR_W-1:0] tail;
	logic [3:0]       occupancy;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			front     <= '0;
			tail      <= '0;
			occupancy <= '0;
		end else begin
			if (push)
				tail <= next_ptr(tail);
			if (pop)
				front <= next_ptr(front);
			// Simultaneous push and pop keeps the count
			case ({push, pop})
				2'b10:   occupancy <= occupancy + 4'd1;
				2'b01:   occupancy <= occupancy - 4'd1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entries[tail] <= push_word;
	end

	assign empty         = (occupancy == 4'd0);
	assign full          = (occupancy == 4'(QUEUE_DEPTH));
	assign head_valid    = !empty;
	assign head_word     = entries[front];
	assign credit_return = pop && !empty;

	assign qfront = 4'(front);
	assign qtail  = 4'(tail);
	assign count  = occupancy;

	// Sender must hold back when out of credits
	a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("inst_queue: push while full");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("inst_queue: pop while empty");

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register and data types
	////////////////////////////////////////////////////////////////////////////

	localparam int REG_COUNT = 16;

	typedef logic [3:0]  reg_addr_t;
	typedef logic [15:0] reg_value_t;

	// Codes 6 to 15 are undefined
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		LI   = 4'd4,
		ADDI = 4'd5
	} opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////////////////////////////////////////

	// Register form
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
	} inst_r_t;

	// Immediate form
	typedef struct packed {
		opcode_t    opcode;
		reg_addr_t  rd;
		logic [7:0] imm8;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_word_u;

endpackage

// ==== design/led_ctrl.sv ====
`timescale 1ns/1ps

module led_ctrl (
	input  logic                clk,
	input  logic                reset,
	input  logic [15:0]         sw,
	input  logic [3:0]          qfront,
	input  logic [3:0]          qtail,
	input  logic [3:0]          count,
	input  logic                empty,
	input  logic                full,
	input  isa_pkg::inst_word_u head_word,
	input  isa_pkg::inst_word_u last_inst,
	input  isa_pkg::reg_value_t last_res,
	input  logic                zero_flag,
	input  logic                decode_error,
	input  logic [255:0]        reg_debug,
	output logic [15:0]         led_data
);
	import debug_pkg::*;

	view_sel_t   view_sel;
	logic [15:0] status_word;
	logic [15:0] view_data;

	assign view_sel = sw[15:8];

	always_comb begin
		status_word = '0;
		status_word[STATUS_EMPTY_BIT] = empty;
		status_word[STATUS_FULL_BIT]  = full;
		status_word[STATUS_ZERO_BIT]  = zero_flag;
		status_word[STATUS_DERR_BIT]  = decode_error;
		status_word[STATUS_COUNT_MSB:STATUS_COUNT_LSB] = count;
	end

	////////////////////////////////////////////////////////////////////////////
	// View select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (view_sel)
			VIEW_STATUS:    view_data = status_word;
			VIEW_LAST_INST: view_data = last_inst;
			VIEW_LAST_RES:  view_data = last_res;
			VIEW_QPTR:      view_data = {4'h0, qfront, 4'h0, qtail};
			VIEW_QHEAD:     view_data = empty ? 16'h0000 : head_word;
			default: begin
				// Register window, else echo the switches
				if (view_sel[7:4] == VIEW_REG_BASE[7:4])
					view_data = reg_debug[{view_sel[3:0], 4'h0} +: 16];
				else
					view_data = sw;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			led_data <= '0;
		else
			led_data <= view_data;
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                reset,
	input  isa_pkg::reg_addr_t  rd_addr1,
	input  isa_pkg::reg_addr_t  rd_addr2,
	input  logic                wr_en,
	input  isa_pkg::reg_addr_t  wr_addr,
	input  isa_pkg::reg_value_t wr_data,
	output isa_pkg::reg_value_t rd_data1,
	output isa_pkg::reg_value_t rd_data2,
	output logic [255:0]        reg_debug
);
	import isa_pkg::*;

	reg_value_t regs [REG_COUNT];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < REG_COUNT; k++)
				regs[k] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// No bypass, a write shows up after the edge
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	// Register n lands in bits 16n+15 down to 16n
	genvar n;
	generate
		for (n = 0; n < REG_COUNT; n++) begin : g_debug
			assign reg_debug[16*n +: 16] = regs[n];
		end
	endgenerate

endmodule

// ==== sources.f ====
design/isa_pkg.sv
design/debug_pkg.sv
design/inst_queue.sv
design/reg_file.sv
design/alu_exec.sv
design/led_ctrl.sv
design/cpu_debug_top.sv
bench/tb_cpu_debug_top.sv
